// ==== all.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/cpu_decode.sv
hdl/regfile.sv
hdl/alu.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
testbench/cpu_chk.sv
testbench/tb_cpu.sv

// ==== hdl/alu.sv ====
`include "cpu_cfg.svh"

module alu import cpu_pkg::*; (
    input  logic [ALU_OP_W-1:0]  alu_op,
    input  logic [`CPU_XLEN-1:0] alu_src1,
    input  logic [`CPU_XLEN-1:0] alu_src2,
    output logic [`CPU_XLEN-1:0] alu_result
);

    logic [`CPU_XLEN-1:0] add_sub_result;
    logic [`CPU_XLEN-1:0] slt_result;
    logic [`CPU_XLEN-1:0] sltu_result;
    logic [`CPU_XLEN-1:0] sll_result;
    logic [`CPU_XLEN-1:0] srl_result;
    logic [`CPU_XLEN-1:0] sra_result;
    logic [4:0]           sa;

    assign add_sub_result = alu_op[ALU_OP_SUB] ? alu_src1 - alu_src2 : alu_src1 + alu_src2;

    assign slt_result  = {{(`CPU_XLEN-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_result = {{(`CPU_XLEN-1){1'b0}}, alu_src1 < alu_src2};

    // Shift amount is the low five bits
    assign sa         = alu_src2[4:0];
    assign sll_result = alu_src1 << sa;
    assign srl_result = alu_src1 >> sa;
    assign sra_result = $signed(alu_src1) >>> sa;

    // One-hot select
    assign alu_result =
          ({`CPU_XLEN{alu_op[ALU_OP_ADD] | alu_op[ALU_OP_SUB]}} & add_sub_result)
        | ({`CPU_XLEN{alu_op[ALU_OP_SLT]}}  & slt_result)
        | ({`CPU_XLEN{alu_op[ALU_OP_SLTU]}} & sltu_result)
        | ({`CPU_XLEN{alu_op[ALU_OP_AND]}}  & (alu_src1 & alu_src2))
        | ({`CPU_XLEN{alu_op[ALU_OP_NOR]}}  & ~(alu_src1 | alu_src2))
        | ({`CPU_XLEN{alu_op[ALU_OP_OR]}}   & (alu_src1 | alu_src2))
        | ({`CPU_XLEN{alu_op[ALU_OP_XOR]}}  & (alu_src1 ^ alu_src2))
        | ({`CPU_XLEN{alu_op[ALU_OP_SLL]}}  & sll_result)
        | ({`CPU_XLEN{alu_op[ALU_OP_SRL]}}  & srl_result)
        | ({`CPU_XLEN{alu_op[ALU_OP_SRA]}}  & sra_result)
        | ({`CPU_XLEN{alu_op[ALU_OP_LUI]}}  & alu_src2);

endmodule

// ==== hdl/cpu_control.sv ====
`include "cpu_cfg.svh"

module cpu_control import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic [`CPU_XLEN-1:0] inst_sram_addr,
    input  logic [ALU_OP_W-1:0]  alu_op,
    input  logic                 src1_is_pc,
    input  logic                 src2_is_imm,
    input  logic [`CPU_XLEN-1:0] imm,
    input  logic [`CPU_XLEN-1:0] br_offs,
    input  logic                 is_branch_cond,
    input  logic                 is_beq,
    input  logic                 is_jump,
    input  logic                 is_jirl,
    input  logic                 mem_re,
    input  logic                 mem_we,
    input  logic                 gr_we,
    input  logic [4:0]           dest,
    input  logic [`CPU_XLEN-1:0] rj_value,
    input  logic [`CPU_XLEN-1:0] rkd_value,
    output logic [`CPU_XLEN-1:0] alu_src1,
    output logic [`CPU_XLEN-1:0] alu_src2,
    output logic [ALU_OP_W-1:0]  alu_op_q,
    input  logic [`CPU_XLEN-1:0] alu_result,
    output logic                 rf_we,
    output logic [4:0]           rf_waddr,
    output logic [`CPU_XLEN-1:0] rf_wdata,
    output logic                 data_sram_we,
    output logic [`CPU_XLEN-1:0] data_sram_addr,
    output logic [`CPU_XLEN-1:0] data_sram_wdata,
    input  logic [`CPU_XLEN-1:0] data_sram_rdata,
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata
);

    localparam logic [2:0] S_IF  = 3'd0;
    localparam logic [2:0] S_ID  = 3'd1;
    localparam logic [2:0] S_EXE = 3'd2;
    localparam logic [2:0] S_MEM = 3'd3;
    localparam logic [2:0] S_WB  = 3'd4;

    logic [2:0]           state, state_nxt;
    logic [`CPU_XLEN-1:0] pc, npc;
    logic                 br_taken;
    logic [`CPU_XLEN-1:0] br_target;
    logic                 mem_re_q, mem_we_q, gr_we_q;
    logic [4:0]           dest_q;
    logic [`CPU_XLEN-1:0] store_data_q;
    logic [`CPU_XLEN-1:0] alu_result_q;

    // Branch resolution in ID
    assign br_taken  = is_jump | (is_branch_cond & (is_beq == (rj_value == rkd_value)));
    assign br_target = (is_jirl ? rj_value : pc) + br_offs;

    always_comb begin
        case (state)
            S_IF:    state_nxt = S_ID;
            S_ID:    state_nxt = (is_branch_cond | (is_jump & ~gr_we)) ? S_IF : S_EXE;
            S_EXE:   state_nxt = (mem_re_q | mem_we_q) ? S_MEM : S_WB;
            S_MEM:   state_nxt = mem_re_q ? S_WB : S_IF;
            default: state_nxt = S_IF;
        endcase
    end

    // pc holds the instruction in flight, npc the next fetch address
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IF;
            pc    <= `CPU_RESET_PC;
            npc   <= `CPU_RESET_PC + 4;
        end else begin
            state <= state_nxt;
            if (state == S_IF) begin
                pc <= npc;
            end
            if (state == S_ID) begin
                npc <= br_taken ? br_target : pc + 4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_ID) begin
            alu_op_q     <= alu_op;
            alu_src1     <= src1_is_pc ? pc : rj_value;
            alu_src2     <= src2_is_imm ? imm : rkd_value;
            store_data_q <= rkd_value;
            mem_re_q     <= mem_re;
            mem_we_q     <= mem_we;
            gr_we_q      <= gr_we;
            dest_q       <= dest;
        end
        if (state == S_EXE) begin
            alu_result_q <= alu_result;
        end
    end

    assign inst_sram_addr = npc;

    assign data_sram_we    = (state == S_MEM) & mem_we_q;
    assign data_sram_addr  = alu_result_q;
    assign data_sram_wdata = store_data_q;

    // Load data arrives in WB
    assign rf_we    = (state == S_WB) & gr_we_q;
    assign rf_waddr = dest_q;
    assign rf_wdata = mem_re_q ? data_sram_rdata : alu_result_q;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== hdl/cpu_decode.sv ====
`include "cpu_cfg.svh"

module cpu_decode import cpu_pkg::*; (
    input  inst_t                 inst,
    output logic [ALU_OP_W-1:0]   alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic [`CPU_XLEN-1:0]  imm,
    output logic [`CPU_XLEN-1:0]  br_offs,
    output logic                  is_branch_cond,
    output logic                  is_beq,
    output logic                  is_jump,
    output logic                  is_jirl,
    output logic                  mem_re,
    output logic                  mem_we,
    output logic                  gr_we,
    output logic [4:0]            dest,
    output logic [4:0]            rf_raddr1,
    output logic [4:0]            rf_raddr2
);

    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic        need_ui5, need_si20, need_si26, src2_is_4;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    // Opcode groups from the register view
    assign grp_3r    = inst.r.op_31_26 == 6'h00 && inst.r.op_25_22 == 4'h0
                    && inst.r.op_21_20 == 2'h1;
    assign grp_shift = inst.r.op_31_26 == 6'h00 && inst.r.op_25_22 == 4'h1
                    && inst.r.op_21_20 == 2'h0;

    assign inst_add_w   = grp_3r && inst.r.op_19_15 == 5'h00;
    assign inst_sub_w   = grp_3r && inst.r.op_19_15 == 5'h02;
    assign inst_slt     = grp_3r && inst.r.op_19_15 == 5'h04;
    assign inst_sltu    = grp_3r && inst.r.op_19_15 == 5'h05;
    assign inst_nor     = grp_3r && inst.r.op_19_15 == 5'h08;
    assign inst_and     = grp_3r && inst.r.op_19_15 == 5'h09;
    assign inst_or      = grp_3r && inst.r.op_19_15 == 5'h0a;
    assign inst_xor     = grp_3r && inst.r.op_19_15 == 5'h0b;
    assign inst_slli_w  = grp_shift && inst.r.op_19_15 == 5'h01;
    assign inst_srli_w  = grp_shift && inst.r.op_19_15 == 5'h09;
    assign inst_srai_w  = grp_shift && inst.r.op_19_15 == 5'h11;
    assign inst_addi_w  = inst.r.op_31_26 == 6'h00 && inst.r.op_25_22 == 4'ha;
    assign inst_ld_w    = inst.r.op_31_26 == 6'h0a && inst.r.op_25_22 == 4'h2;
    assign inst_st_w    = inst.r.op_31_26 == 6'h0a && inst.r.op_25_22 == 4'h6;
    assign inst_lu12i_w = inst.i.op_31_26 == 6'h05 && !inst.i.f.s20.op_25;
    assign inst_jirl    = inst.i.op_31_26 == 6'h13;
    assign inst_b       = inst.i.op_31_26 == 6'h14;
    assign inst_bl      = inst.i.op_31_26 == 6'h15;
    assign inst_beq     = inst.i.op_31_26 == 6'h16;
    assign inst_bne     = inst.i.op_31_26 == 6'h17;

    assign alu_op[ALU_OP_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                               | inst_jirl | inst_bl;
    assign alu_op[ALU_OP_SUB]  = inst_sub_w;
    assign alu_op[ALU_OP_SLT]  = inst_slt;
    assign alu_op[ALU_OP_SLTU] = inst_sltu;
    assign alu_op[ALU_OP_AND]  = inst_and;
    assign alu_op[ALU_OP_NOR]  = inst_nor;
    assign alu_op[ALU_OP_OR]   = inst_or;
    assign alu_op[ALU_OP_XOR]  = inst_xor;
    assign alu_op[ALU_OP_SLL]  = inst_slli_w;
    assign alu_op[ALU_OP_SRL]  = inst_srli_w;
    assign alu_op[ALU_OP_SRA]  = inst_srai_w;
    assign alu_op[ALU_OP_LUI]  = inst_lu12i_w;

    // Immediates from the immediate view
    assign i12 = inst.i.f.s12.i12;
    assign i16 = inst.i.f.s16.i16;
    assign i20 = inst.i.f.s20.i20;
    assign i26 = {inst.i.f.s26.i26_hi, inst.i.f.s26.i26_lo};

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    // Link value is computed as pc + 4
    assign src2_is_4 = inst_jirl | inst_bl;

    assign imm = src2_is_4 ? `CPU_XLEN'(4) :
                 need_si20 ? {i20, 12'b0} :
                 need_ui5  ? {{(`CPU_XLEN-5){1'b0}}, inst.r.rk} :
                             {{(`CPU_XLEN-12){i12[11]}}, i12};

    assign br_offs = need_si26 ? {{(`CPU_XLEN-28){i26[25]}}, i26, 2'b0} :
                                 {{(`CPU_XLEN-18){i16[15]}}, i16, 2'b0};

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w
                       | inst_lu12i_w | inst_jirl | inst_bl;

    assign is_branch_cond = inst_beq | inst_bne;
    assign is_beq         = inst_beq;
    assign is_jump        = inst_b | inst_bl | inst_jirl;
    assign is_jirl        = inst_jirl;
    assign mem_re         = inst_ld_w;
    assign mem_we         = inst_st_w;

    // Only known writers set gr_we
    assign gr_we = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                 | inst_and | inst_or | inst_xor | need_ui5 | inst_addi_w
                 | inst_lu12i_w | inst_ld_w | inst_jirl | inst_bl;

    assign dest      = inst_bl ? 5'd1 : inst.r.rd;
    assign rf_raddr1 = inst.r.rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? inst.r.rd : inst.r.rk;

endmodule

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // Register and opcode fields
    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } inst_reg_t;

    // Immediate layouts below the primary opcode
    typedef struct packed {
        logic [3:0]  op_25_22;
        logic [11:0] i12;
        logic [9:0]  rj_rd;
    } imm_si12_t;

    typedef struct packed {
        logic [15:0] i16;
        logic [9:0]  rj_rd;
    } imm_si16_t;

    typedef struct packed {
        logic        op_25;
        logic [19:0] i20;
        logic [4:0]  rd;
    } imm_si20_t;

    typedef struct packed {
        logic [15:0] i26_lo;
        logic [9:0]  i26_hi;
    } imm_si26_t;

    typedef union packed {
        imm_si12_t s12;
        imm_si16_t s16;
        imm_si20_t s20;
        imm_si26_t s26;
    } imm_field_t;

    typedef struct packed {
        logic [5:0] op_31_26;
        imm_field_t f;
    } inst_imm_t;

    typedef union packed {
        inst_reg_t r;
        inst_imm_t i;
    } inst_t;

    // One-hot ALU operation bits
    localparam int ALU_OP_W    = 12;
    localparam int ALU_OP_ADD  = 0;
    localparam int ALU_OP_SUB  = 1;
    localparam int ALU_OP_SLT  = 2;
    localparam int ALU_OP_SLTU = 3;
    localparam int ALU_OP_AND  = 4;
    localparam int ALU_OP_NOR  = 5;
    localparam int ALU_OP_OR   = 6;
    localparam int ALU_OP_XOR  = 7;
    localparam int ALU_OP_SLL  = 8;
    localparam int ALU_OP_SRL  = 9;
    localparam int ALU_OP_SRA  = 10;
    localparam int ALU_OP_LUI  = 11;

endpackage

// ==== hdl/cpu_top.sv ====
`include "cpu_cfg.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic [`CPU_XLEN-1:0] inst_sram_addr,
    input  logic [`CPU_XLEN-1:0] inst_sram_rdata,
    output logic                 data_sram_we,
    output logic [`CPU_XLEN-1:0] data_sram_addr,
    output logic [`CPU_XLEN-1:0] data_sram_wdata,
    input  logic [`CPU_XLEN-1:0] data_sram_rdata,
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_we,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata
);

    logic [ALU_OP_W-1:0]  alu_op, alu_op_q;
    logic                 src1_is_pc, src2_is_imm;
    logic [`CPU_XLEN-1:0] imm, br_offs;
    logic                 is_branch_cond, is_beq, is_jump, is_jirl;
    logic                 mem_re, mem_we, gr_we;
    logic [4:0]           dest;
    logic [4:0]           rf_raddr1, rf_raddr2, rf_waddr;
    logic [`CPU_XLEN-1:0] rj_value, rkd_value;
    logic                 rf_we;
    logic [`CPU_XLEN-1:0] rf_wdata;
    logic [`CPU_XLEN-1:0] alu_src1, alu_src2, alu_result;

    // Decoder sees the fetched word during ID
    cpu_decode u_cpu_decode (
        .inst           (inst_sram_rdata),
        .alu_op         (alu_op),
        .src1_is_pc     (src1_is_pc),
        .src2_is_imm    (src2_is_imm),
        .imm            (imm),
        .br_offs        (br_offs),
        .is_branch_cond (is_branch_cond),
        .is_beq         (is_beq),
        .is_jump        (is_jump),
        .is_jirl        (is_jirl),
        .mem_re         (mem_re),
        .mem_we         (mem_we),
        .gr_we          (gr_we),
        .dest           (dest),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .alu_op     (alu_op_q),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    cpu_control u_cpu_control (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .alu_op            (alu_op),
        .src1_is_pc        (src1_is_pc),
        .src2_is_imm       (src2_is_imm),
        .imm               (imm),
        .br_offs           (br_offs),
        .is_branch_cond    (is_branch_cond),
        .is_beq            (is_beq),
        .is_jump           (is_jump),
        .is_jirl           (is_jirl),
        .mem_re            (mem_re),
        .mem_we            (mem_we),
        .gr_we             (gr_we),
        .dest              (dest),
        .rj_value          (rj_value),
        .rkd_value         (rkd_value),
        .alu_src1          (alu_src1),
        .alu_src2          (alu_src2),
        .alu_op_q          (alu_op_q),
        .alu_result        (alu_result),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// ==== hdl/regfile.sv ====
`include "cpu_cfg.svh"

module regfile (
    input  logic                 clk,
    input  logic [4:0]           raddr1,
    output logic [`CPU_XLEN-1:0] rdata1,
    input  logic [4:0]           raddr2,
    output logic [`CPU_XLEN-1:0] rdata2,
    input  logic                 we,
    input  logic [4:0]           waddr,
    input  logic [`CPU_XLEN-1:0] wdata
);

    logic [`CPU_XLEN-1:0] rf [31:0];

    // Writes to r0 are dropped
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// PC held in reset, first fetch goes to the next word
`define CPU_RESET_PC 32'h1bff_fffc

// Datapath width
`define CPU_XLEN 32

`endif

// ==== testbench/cpu_chk.sv ====
module cpu_chk (
    input logic       clk,
    input logic       reset,
    input logic       data_sram_we,
    input logic [3:0] debug_wb_rf_we
);

    int assertion_errors = 0;

    // Trace enable moves as one
    trace_we_whole: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
        else begin
            assertion_errors++;
            $error("trace write enable is partly set: %b", debug_wb_rf_we);
        end

    // Store and writeback live in different states
    store_wb_apart: assert property (@(posedge clk) disable iff (reset)
        !(data_sram_we && debug_wb_rf_we != 4'h0))
        else begin
            assertion_errors++;
            $error("data SRAM write and register writeback in the same cycle");
        end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!data_sram_we && debug_wb_rf_we == 4'h0))
        else begin
            assertion_errors++;
            $error("write strobes active in the cycle after reset");
        end

endmodule

// ==== testbench/cpu_vectors.mem ====
// Program words from 1c000000, four per line
// Then trace records, one per line, as pc wnum wdata
// wnum bit 8 set means wdata holds a load address, expect the seeded word there
142468a1 0299e002 00100823 02bffc04  // lu12i.w r1 / addi.w r2 / add.w r3 / addi.w r4 -1
00111045 00120886 00128887 00140068  // sub.w r5 / slt r6 / sltu r7 / nor r8
00148869 0015090a 0015846b 0040904c  // and r9 / or r10 / xor r11 / slli.w r12
0044a10d 0048a10e 02801440 29802043  // srli.w r13 / srai.w r14 / addi.w r0 / st.w r3
28802051 2880a052 58000871 02800413  // ld.w r17 / ld.w r18 / beq taken / skipped
5c000871 02800814 5c000844 02800c15  // bne not taken / addi.w r20 / bne taken / skipped
58000844 0010080f 50000800 4c000437  // beq not taken / add.w r15 / b / jirl r23 r1 +4
57ffffff 02801818 02801016 50000000  // bl back / skipped / addi.w r22 / self-loop b
1c000000 00000001 12345000
1c000004 00000002 00000678
1c000008 00000003 12345678
1c00000c 00000004 ffffffff
1c000010 00000005 00000679
1c000014 00000006 00000001
1c000018 00000007 00000000
1c00001c 00000008 edcba987
1c000020 00000009 00000678
1c000024 0000000a edcbafff
1c000028 0000000b 00000678
1c00002c 0000000c 00006780
1c000030 0000000d 00edcba9
1c000034 0000000e ffedcba9
1c000038 00000000 0000067d
1c000040 00000011 12345678
1c000044 00000112 000006a0
1c000054 00000014 00000002
1c000064 0000000f 00000678
1c000070 00000001 1c000074
1c00006c 00000017 1c000070
1c000078 00000016 00000004
// End marker
ffffffff ffffffff ffffffff

// ==== testbench/tb_cpu.sv ====
`include "cpu_cfg.svh"

module tb_cpu;

    localparam int          PROG_WORDS = 32;
    localparam int          VEC_WORDS  = 256;
    localparam int          DMEM_WORDS = 1024;
    localparam int          TIMEOUT    = 20;
    localparam logic [31:0] PROG_BASE  = `CPU_RESET_PC + 32'd4;
    localparam logic [31:0] END_MARK   = 32'hffff_ffff;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] vectors [0:VEC_WORDS-1];
    logic [31:0] imem [0:PROG_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] dmem_init [0:DMEM_WORDS-1];
    logic [31:0] fetch_addr;
    logic [9:0]  load_index;

    int errors;
    int records_seen;
    int expected_count;

    cpu_top u_cpu_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind cpu_top cpu_chk u_cpu_chk (
        .clk            (clk),
        .reset          (reset),
        .data_sram_we   (data_sram_we),
        .debug_wb_rf_we (debug_wb_rf_we)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - PROG_BASE;
        if (offset < 32'(PROG_WORDS * 4)) begin
            return imem[offset[6:2]];
        end
        return 32'h0;
    endfunction

    // Wnum bit 8 marks a load from untouched memory
    function automatic logic [31:0] expected_wdata(input logic [31:0] wnum_col,
                                                   input logic [31:0] wdata_col);
        if (wnum_col[8]) begin
            return dmem_init[wdata_col[11:2]];
        end
        return wdata_col;
    endfunction

    // Both SRAMs answer one cycle after the address
    always @(posedge clk) begin
        fetch_addr = inst_sram_addr;
        load_index = data_sram_addr[11:2];
        if (data_sram_we === 1'b1) begin
            dmem[data_sram_addr[11:2]] = data_sram_wdata;
        end
        #1;
        inst_sram_rdata = fetch_word(fetch_addr);
        data_sram_rdata = dmem[load_index];
    end

    task automatic wait_trace(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            if (debug_wb_rf_we !== 4'h0) begin
                seen = 1'b1;
            end
            n++;
        end
    endtask

    task automatic compare_record(input int idx);
        logic [31:0] exp_pc;
        logic [31:0] exp_wnum;
        logic [31:0] exp_wdata;
        exp_pc    = vectors[PROG_WORDS + 3 * idx];
        exp_wnum  = vectors[PROG_WORDS + 3 * idx + 1];
        exp_wdata = expected_wdata(exp_wnum, vectors[PROG_WORDS + 3 * idx + 2]);
        if (debug_wb_pc !== exp_pc) begin
            errors++;
            $display("error trace %0d pc: expected %h actual %h", idx, exp_pc, debug_wb_pc);
        end
        if (debug_wb_rf_wnum !== exp_wnum[4:0]) begin
            errors++;
            $display("error trace %0d wnum: expected %0d actual %0d",
                     idx, exp_wnum[4:0], debug_wb_rf_wnum);
        end
        if (debug_wb_rf_wdata !== exp_wdata) begin
            errors++;
            $display("error trace %0d wdata: expected %h actual %h",
                     idx, exp_wdata, debug_wb_rf_wdata);
        end
    endtask

    initial begin
        int i;
        int k;
        int chk_errors;
        bit seen;
        bit stop;
        reset           = 1'b1;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        errors          = 0;
        records_seen    = 0;
        expected_count  = 0;
        void'($urandom(50));

        $readmemh("testbench/cpu_vectors.mem", vectors);
        for (i = 0; i < PROG_WORDS; i++) begin
            imem[i] = vectors[i];
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem_init[i] = $urandom();
            dmem[i]      = dmem_init[i];
        end

        k = PROG_WORDS;
        while (k < VEC_WORDS && vectors[k] !== END_MARK) begin
            k += 3;
        end
        if (k >= VEC_WORDS) begin
            errors++;
            $display("the vector file has no end marker");
        end
        expected_count = (k - PROG_WORDS) / 3;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        stop = 1'b0;
        for (i = 0; i < expected_count && !stop; i++) begin
            wait_trace(seen);
            if (seen) begin
                records_seen++;
                compare_record(i);
            end else begin
                errors++;
                $display("timeout: trace record %0d did not appear within %0d cycles",
                         i, TIMEOUT);
                stop = 1'b1;
            end
        end

        // Self-loop at the end must stay silent
        if (!stop) begin
            wait_trace(seen);
            if (seen) begin
                errors++;
                $display("unexpected trace record after the last one, pc %h", debug_wb_pc);
            end
        end

        chk_errors = u_cpu_top.u_cpu_chk.assertion_errors;
        $display("check errors %0d, assertion errors %0d, trace records %0d of %0d",
                 errors, chk_errors, records_seen, expected_count);
        if (errors == 0 && chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
